/* src/armPkg.sv */
// ARM core shared definitions
package armPkg;

   localparam int wordWidth = 32;
   localparam logic [3:0] pcRegIdx = 4'd15;
   localparam logic [3:0] linkRegIdx = 4'd14;
   localparam logic [3:0] condAlways = 4'b1110;

   // Major opcode field
   localparam logic [1:0] opDataProc = 2'b00;
   localparam logic [1:0] opMemory = 2'b01;
   localparam logic [1:0] opBranch = 2'b10;

   // Data-processing funct[4:1]
   localparam logic [3:0] functAdd = 4'b0100;
   localparam logic [3:0] functSub = 4'b0010;
   localparam logic [3:0] functAnd = 4'b0000;
   localparam logic [3:0] functOrr = 4'b1100;

   typedef enum logic [1:0] {shiftLsl = 2'b00, shiftLsr = 2'b01, shiftAsr = 2'b10,
                             shiftRor = 2'b11} shiftType;

   typedef enum logic [1:0] {aluAdd = 2'b00, aluSub = 2'b01, aluAnd = 2'b10,
                             aluOrr = 2'b11} aluOp;

   typedef enum logic [1:0] {immByte = 2'b00, immWord12 = 2'b01,
                             immBranch = 2'b10} immSel;

   typedef struct packed {
      logic [3:0] cond;
      logic [1:0] op;
      logic [5:0] funct;
      logic [3:0] rn;
      logic [3:0] rd;
      logic [11:0] low12;
   } commonView;

   // Register form; low byte doubles as imm8 in the immediate form
   typedef struct packed {
      logic [11:0] head;
      logic [3:0] rn;
      logic [3:0] rd;
      logic [4:0] shamt;
      shiftType shType;
      logic regShift;
      logic [3:0] rm;
   } dpView;

   typedef struct packed {
      logic [19:0] head;
      logic [11:0] offset;
   } memView;

   typedef struct packed {
      logic [7:0] head;
      logic [23:0] offset;
   } branchView;

   typedef union packed {
      commonView common;
      dpView dp;
      memView mem;
      branchView branch;
   } instrWord;

   // regSrc bits: [0] base is PC, [1] store data from rd, [2] link
   typedef struct packed {
      logic [2:0] regSrc;
      immSel immSrc;
      logic aluSrcImm;
      logic memToReg;
      logic regW;
      logic memW;
      logic pcS;
      logic [1:0] flagW;
      aluOp aluControl;
      logic memStrobe;
   } ctrlFields;

   typedef struct packed {
      logic neg;
      logic zero;
      logic carry;
      logic overflow;
   } aluFlags;

endpackage

/* src/alu.sv */
// ALU with NZCV flags
`timescale 1ns/1ps

module alu
(
   input  logic [armPkg::wordWidth-1:0] a,
   input  logic [armPkg::wordWidth-1:0] b,
   input  armPkg::aluOp op,
   output logic [armPkg::wordWidth-1:0] result,
   output armPkg::aluFlags flags
);

   logic [armPkg::wordWidth-1:0] condInvB;
   logic [armPkg::wordWidth:0] sum;
   logic isArith;

   // SUB is a plus inverted b plus one
   assign condInvB = op[0] ? ~b : b;
   assign sum = {1'b0, a} + {1'b0, condInvB} + {32'b0, op[0]};
   assign isArith = ~op[1];

   always_comb
   begin
      case (op)
         armPkg::aluAdd: result = sum[armPkg::wordWidth-1:0];
         armPkg::aluSub: result = sum[armPkg::wordWidth-1:0];
         armPkg::aluAnd: result = a & b;
         armPkg::aluOrr: result = a | b;
         default: result = '0;
      endcase
   end

   assign flags.neg = result[armPkg::wordWidth-1];
   assign flags.zero = (result == '0);
   assign flags.carry = isArith & sum[armPkg::wordWidth];
   // Operands of equal effective sign, result of the other
   assign flags.overflow = isArith & ~(a[31] ^ b[31] ^ op[0]) & (a[31] ^ sum[31]);

endmodule

/* src/operandUnit.sv */
// Second operand, immediates and barrel shifter
`timescale 1ns/1ps

module operandUnit
(
   input  armPkg::instrWord Instr,
   input  armPkg::ctrlFields ctrl,
   input  logic [armPkg::wordWidth-1:0] regData,
   output logic [armPkg::wordWidth-1:0] srcB
);

   logic [armPkg::wordWidth-1:0] extImm;
   logic [armPkg::wordWidth-1:0] shifted;
   logic [2*armPkg::wordWidth-1:0] rotPair;
   logic [4:0] shamt;

   assign shamt = Instr.dp.shamt;

   // Immediate forms
   always_comb
   begin
      case (ctrl.immSrc)
         armPkg::immByte: extImm = {24'b0, Instr.common.low12[7:0]};
         armPkg::immWord12: extImm = {20'b0, Instr.mem.offset};
         // Word offset, sign-extended
         armPkg::immBranch:
         begin
            extImm = {{6{Instr.branch.offset[23]}}, Instr.branch.offset, 2'b00};
         end
         default: extImm = '0;
      endcase
   end

   // Doubled word makes rotation a plain right shift
   assign rotPair = {regData, regData} >> shamt;

   always_comb
   begin
      case (Instr.dp.shType)
         armPkg::shiftLsl: shifted = regData << shamt;
         armPkg::shiftLsr: shifted = regData >> shamt;
         armPkg::shiftAsr: shifted = $signed(regData) >>> shamt;
         armPkg::shiftRor: shifted = rotPair[armPkg::wordWidth-1:0];
         default: shifted = regData;
      endcase
   end

   assign srcB = ctrl.aluSrcImm ? extImm : shifted;

endmodule

/* src/regFile.sv */
// Register file with R15 read as PC+8
`timescale 1ns/1ps

module regFile
(
   input  logic clk,
   input  armPkg::instrWord Instr,
   input  armPkg::ctrlFields ctrl,
   input  logic regWrite,
   input  logic [armPkg::wordWidth-1:0] result,
   input  logic [armPkg::wordWidth-1:0] pcPlus4,
   input  logic [armPkg::wordWidth-1:0] pcPlus8,
   output logic [armPkg::wordWidth-1:0] srcA,
   output logic [armPkg::wordWidth-1:0] WriteData
);

   logic [armPkg::wordWidth-1:0] regs [14:0];
   logic [3:0] readAddrA;
   logic [3:0] readAddrB;
   logic [3:0] writeAddr;
   logic [armPkg::wordWidth-1:0] writeValue;

   // Address steering from regSrc
   assign readAddrA = ctrl.regSrc[0] ? armPkg::pcRegIdx : Instr.dp.rn;
   assign readAddrB = ctrl.regSrc[1] ? Instr.dp.rd : Instr.dp.rm;
   assign writeAddr = ctrl.regSrc[2] ? armPkg::linkRegIdx : Instr.dp.rd;
   assign writeValue = ctrl.regSrc[2] ? pcPlus4 : result;

   // R15 itself lives in the PC unit
   always_ff @(posedge clk)
   begin
      if (regWrite && writeAddr != armPkg::pcRegIdx)
      begin
         regs[writeAddr] <= writeValue;
      end
   end

   assign srcA = (readAddrA == armPkg::pcRegIdx) ? pcPlus8 : regs[readAddrA];
   assign WriteData = (readAddrB == armPkg::pcRegIdx) ? pcPlus8 : regs[readAddrB];

endmodule

/* src/pcUnit.sv */
// Program counter
`timescale 1ns/1ps

module pcUnit
(
   input  logic clk,
   input  logic reset,
   input  logic PCReady,
   input  logic pcSrc,
   input  logic [armPkg::wordWidth-1:0] target,
   output logic [armPkg::wordWidth-1:0] PC,
   output logic [armPkg::wordWidth-1:0] pcPlus4,
   output logic [armPkg::wordWidth-1:0] pcPlus8
);

   logic [armPkg::wordWidth-1:0] pcNext;

   assign pcPlus4 = PC + 32'd4;
   assign pcPlus8 = PC + 32'd8;

   // Branch or R15 write takes the target
   assign pcNext = pcSrc ? target : pcPlus4;

   // Holds while PCReady is low
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         PC <= '0;
      end
      else if (PCReady)
      begin
         PC <= pcNext;
      end
   end

endmodule

/* src/condUnit.sv */
// Condition flags and write gating
`timescale 1ns/1ps

module condUnit
(
   input  logic clk,
   input  logic reset,
   input  logic PCReady,
   input  logic [3:0] cond,
   input  armPkg::ctrlFields ctrl,
   input  armPkg::aluFlags flagsIn,
   output logic regWrite,
   output logic memWrite,
   output logic pcSrc
);

   armPkg::aluFlags flags;
   logic condEx;
   logic commit;
   logic ge;
   logic [1:0] flagWrite;

   assign ge = (flags.neg == flags.overflow);

   always_comb
   begin
      case (cond)
         4'b0000: condEx = flags.zero;
         4'b0001: condEx = ~flags.zero;
         4'b0010: condEx = flags.carry;
         4'b0011: condEx = ~flags.carry;
         4'b0100: condEx = flags.neg;
         4'b0101: condEx = ~flags.neg;
         4'b0110: condEx = flags.overflow;
         4'b0111: condEx = ~flags.overflow;
         4'b1000: condEx = flags.carry & ~flags.zero;
         4'b1001: condEx = ~(flags.carry & ~flags.zero);
         4'b1010: condEx = ge;
         4'b1011: condEx = ~ge;
         4'b1100: condEx = ~flags.zero & ge;
         4'b1101: condEx = ~(~flags.zero & ge);
         armPkg::condAlways: condEx = 1'b1;
         // 1111 never executes
         default: condEx = 1'b0;
      endcase
   end

   // Only an executing instruction at an advance edge commits
   assign commit = condEx & PCReady & ~reset;
   assign flagWrite = ctrl.flagW & {2{commit}};
   assign regWrite = ctrl.regW & commit;
   assign memWrite = ctrl.memW & commit;
   assign pcSrc = ctrl.pcS & commit;

   // NZ and CV pairs with separate enables
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         flags <= '0;
      end
      else
      begin
         if (flagWrite[1])
         begin
            flags.neg <= flagsIn.neg;
            flags.zero <= flagsIn.zero;
         end
         if (flagWrite[0])
         begin
            flags.carry <= flagsIn.carry;
            flags.overflow <= flagsIn.overflow;
         end
      end
   end

endmodule

/* src/instrDecoder.sv */
// Instruction decoder
`timescale 1ns/1ps

module instrDecoder
(
   input  armPkg::instrWord Instr,
   output armPkg::ctrlFields ctrl
);

   logic isBranch;
   logic isDataProc;
   logic [5:0] funct;
   armPkg::aluOp dpOp;

   assign funct = Instr.common.funct;
   assign isDataProc = (Instr.common.op == armPkg::opDataProc);

   // ALU decoding for data-processing instructions
   always_comb
   begin
      case (funct[4:1])
         armPkg::functAdd: dpOp = armPkg::aluAdd;
         armPkg::functSub: dpOp = armPkg::aluSub;
         armPkg::functAnd: dpOp = armPkg::aluAnd;
         armPkg::functOrr: dpOp = armPkg::aluOrr;
         default: dpOp = armPkg::aluAdd;
      endcase
   end

   // Main decoding
   always_comb
   begin
      ctrl = '0;
      isBranch = 1'b0;
      case (Instr.common.op)
         armPkg::opDataProc:
         begin
            ctrl.immSrc = armPkg::immByte;
            ctrl.aluSrcImm = funct[5];
            ctrl.regW = 1'b1;
         end
         armPkg::opMemory:
         begin
            ctrl.immSrc = armPkg::immWord12;
            ctrl.aluSrcImm = 1'b1;
            ctrl.memStrobe = 1'b1;
            // L bit picks load or store
            if (funct[0])
            begin
               ctrl.memToReg = 1'b1;
               ctrl.regW = 1'b1;
            end
            else
            begin
               ctrl.regSrc = 3'b010;
               ctrl.memW = 1'b1;
            end
         end
         armPkg::opBranch:
         begin
            ctrl.immSrc = armPkg::immBranch;
            ctrl.aluSrcImm = 1'b1;
            isBranch = 1'b1;
            // BL also writes the link register
            if (funct[4])
            begin
               ctrl.regSrc = 3'b101;
               ctrl.regW = 1'b1;
            end
            else
            begin
               ctrl.regSrc = 3'b001;
            end
         end
         default:
         begin
            ctrl = '0;
         end
      endcase

      if (isDataProc)
      begin
         ctrl.aluControl = dpOp;
         ctrl.flagW[1] = funct[0];
         // C and V only from arithmetic
         ctrl.flagW[0] = funct[0] & ~dpOp[1];
      end

      // Branches and writes to R15 redirect the PC
      ctrl.pcS = isBranch | (ctrl.regW & (Instr.common.rd == armPkg::pcRegIdx));
   end

endmodule

/* src/armCore.sv */
// Single-cycle ARM core top level
`timescale 1ns/1ps

module armCore
(
   input  logic clk,
   input  logic reset,
   input  armPkg::instrWord Instr,
   output logic [armPkg::wordWidth-1:0] PC,
   output logic MemWrite,
   output logic [armPkg::wordWidth-1:0] ALUResult,
   output logic [armPkg::wordWidth-1:0] WriteData,
   input  logic [armPkg::wordWidth-1:0] ReadData,
   output logic MemStrobe,
   input  logic PCReady
);

   armPkg::ctrlFields ctrl;
   armPkg::aluFlags flags;
   logic regWrite;
   logic pcSrc;
   logic [armPkg::wordWidth-1:0] pcPlus4;
   logic [armPkg::wordWidth-1:0] pcPlus8;
   logic [armPkg::wordWidth-1:0] srcA;
   logic [armPkg::wordWidth-1:0] srcB;
   logic [armPkg::wordWidth-1:0] result;

   // Load data or ALU result, also the branch target
   assign result = ctrl.memToReg ? ReadData : ALUResult;
   assign MemStrobe = ctrl.memStrobe;

   instrDecoder decodeUnit (.Instr(Instr), .ctrl(ctrl));

   condUnit condCheck (.clk(clk), .reset(reset), .PCReady(PCReady), .cond(Instr.common.cond),
                       .ctrl(ctrl), .flagsIn(flags), .regWrite(regWrite),
                       .memWrite(MemWrite), .pcSrc(pcSrc));

   pcUnit pcReg (.clk(clk), .reset(reset), .PCReady(PCReady), .pcSrc(pcSrc), .target(result),
                 .PC(PC), .pcPlus4(pcPlus4), .pcPlus8(pcPlus8));

   regFile regs (.clk(clk), .Instr(Instr), .ctrl(ctrl), .regWrite(regWrite), .result(result),
                 .pcPlus4(pcPlus4), .pcPlus8(pcPlus8), .srcA(srcA), .WriteData(WriteData));

   operandUnit operand (.Instr(Instr), .ctrl(ctrl), .regData(WriteData), .srcB(srcB));

   alu aluUnit (.a(srcA), .b(srcB), .op(ctrl.aluControl), .result(ALUResult), .flags(flags));

endmodule

/* bench/armCore_properties.sv */
// ARM core interface properties
`timescale 1ns/1ps

module armCoreProperties
(
   input logic clk,
   input logic reset,
   input logic [31:0] PC,
   input logic PCReady,
   input logic MemWrite,
   input logic MemStrobe
);

   // A store is always a memory access
   memWriteHasStrobe: assert property (@(posedge clk) disable iff (reset)
      MemWrite |-> MemStrobe)
      else $error("MemWrite high without MemStrobe");

   pcWordAligned: assert property (@(posedge clk) disable iff (reset)
      PC[1:0] == 2'b00)
      else $error("PC is not word aligned");

   // Stall holds the program counter
   pcHeldOnStall: assert property (@(posedge clk) disable iff (reset)
      !PCReady |=> $stable(PC))
      else $error("PC moved after a stalled cycle");

   pcClearInReset: assert property (@(posedge clk)
      reset |-> PC == 32'd0)
      else $error("PC not zero during reset");

endmodule

/* bench/armCoreTb.sv */
// ARM core testbench
`timescale 1ns/1ps

module armCoreTb;

   localparam logic [3:0] cEq = 4'h0;
   localparam logic [3:0] cNe = 4'h1;
   localparam logic [3:0] cCs = 4'h2;
   localparam logic [3:0] cCc = 4'h3;
   localparam logic [3:0] cMi = 4'h4;
   localparam logic [3:0] cHi = 4'h8;
   localparam logic [3:0] cGe = 4'hA;
   localparam logic [3:0] cLt = 4'hB;
   localparam logic [3:0] cGt = 4'hC;
   localparam logic [3:0] cLe = 4'hD;
   localparam logic [3:0] cAl = 4'hE;
   localparam logic [3:0] cNv = 4'hF;
   localparam int clkPeriod = 8;

   typedef struct packed {
      logic [31:0] instr;
      logic [31:0] alu;
      logic chkWd;
      logic [31:0] wd;
      logic memW;
      logic [31:0] pc;
   } stimRow;

   logic clk;
   logic reset;
   armPkg::instrWord Instr;
   logic [31:0] PC;
   logic MemWrite;
   logic [31:0] ALUResult;
   logic [31:0] WriteData;
   logic [31:0] ReadData;
   logic MemStrobe;
   logic PCReady;

   stimRow rows[$];
   logic [31:0] dataMem [0:63];
   logic [31:0] lfsrState;
   logic tableReady;

   armCore dut_i (.clk(clk), .reset(reset), .Instr(Instr), .PC(PC), .MemWrite(MemWrite),
                  .ALUResult(ALUResult), .WriteData(WriteData), .ReadData(ReadData),
                  .MemStrobe(MemStrobe), .PCReady(PCReady));

   bind armCore armCoreProperties props_i (.clk(clk), .reset(reset), .PC(PC),
                                           .PCReady(PCReady), .MemWrite(MemWrite),
                                           .MemStrobe(MemStrobe));

   initial
   begin
      clk = 1'b0;
      forever #(clkPeriod / 2) clk = ~clk;
   end

   // Data memory model, word indexed
   function automatic logic [31:0] memFill(input int idx);
      return 32'hC0DE0000 + idx * 32'h101;
   endfunction

   initial
   begin
      for (int i = 0; i < 64; i++)
      begin
         dataMem[i] = memFill(i);
      end
   end

   assign ReadData = dataMem[ALUResult[7:2]];

   always @(posedge clk)
   begin
      if (MemWrite)
      begin
         dataMem[ALUResult[7:2]] <= WriteData;
      end
   end

   // Instruction encoders
   function automatic logic [31:0] dpImm(input logic [3:0] cond, input logic [3:0] funct,
                                         input logic s, input logic [3:0] rn,
                                         input logic [3:0] rd, input logic [7:0] imm);
      return {cond, 2'b00, 1'b1, funct, s, rn, rd, 4'h0, imm};
   endfunction

   function automatic logic [31:0] dpReg(input logic [3:0] cond, input logic [3:0] funct,
                                         input logic s, input logic [3:0] rn,
                                         input logic [3:0] rd, input logic [4:0] shamt,
                                         input logic [1:0] sh, input logic [3:0] rm);
      return {cond, 2'b00, 1'b0, funct, s, rn, rd, shamt, sh, 1'b0, rm};
   endfunction

   function automatic logic [31:0] memOp(input logic [3:0] cond, input logic load,
                                         input logic [3:0] rn, input logic [3:0] rd,
                                         input logic [11:0] offset);
      return {cond, 2'b01, 5'b01100, load, rn, rd, offset};
   endfunction

   function automatic logic [31:0] branchOp(input logic [3:0] cond, input logic link,
                                            input logic [23:0] offset);
      return {cond, 3'b101, link, offset};
   endfunction

   task automatic addRow(input logic [31:0] instr, input logic [31:0] alu, input logic chkWd,
                         input logic [31:0] wd, input logic memW, input logic [31:0] pc);
      stimRow r;
      r.instr = instr;
      r.alu = alu;
      r.chkWd = chkWd;
      r.wd = wd;
      r.memW = memW;
      r.pc = pc;
      rows.push_back(r);
   endtask

   task automatic buildTable();
      // Operands through immediates, R15 as PC+8
      addRow(dpReg(cAl, armPkg::functSub, 0, 15, 0, 0, armPkg::shiftLsl, 15), 0, 1, 8, 0, 4);
      addRow(dpImm(cAl, armPkg::functAdd, 0, 0, 1, 8'd5), 5, 0, 0, 0, 8);
      addRow(dpImm(cAl, armPkg::functAdd, 0, 0, 2, 8'd3), 3, 0, 0, 0, 12);
      addRow(dpImm(cAl, armPkg::functAdd, 0, 0, 3, 8'h3C), 32'h3C, 0, 0, 0, 16);
      addRow(dpReg(cAl, armPkg::functAdd, 0, 1, 4, 0, armPkg::shiftLsl, 2), 8, 1, 3, 0, 20);
      addRow(dpReg(cAl, armPkg::functSub, 0, 1, 5, 0, armPkg::shiftLsl, 2), 2, 1, 3, 0, 24);
      addRow(dpReg(cAl, armPkg::functAnd, 0, 3, 6, 0, armPkg::shiftLsl, 1), 4, 1, 5, 0, 28);
      addRow(dpReg(cAl, armPkg::functOrr, 0, 3, 7, 0, armPkg::shiftLsl, 1), 32'h3D, 1, 5, 0,
             32);
      // Shift types
      addRow(dpReg(cAl, armPkg::functAdd, 0, 0, 8, 4, armPkg::shiftLsl, 1), 32'h50, 1, 5, 0,
             36);
      addRow(dpReg(cAl, armPkg::functSub, 0, 0, 9, 0, armPkg::shiftLsl, 1), 32'hFFFFFFFB, 1, 5,
             0, 40);
      addRow(dpReg(cAl, armPkg::functAdd, 0, 0, 10, 1, armPkg::shiftAsr, 9), 32'hFFFFFFFD, 1,
             32'hFFFFFFFB, 0, 44);
      addRow(dpReg(cAl, armPkg::functAdd, 0, 0, 11, 4, armPkg::shiftLsr, 9), 32'h0FFFFFFF, 0,
             0, 0, 48);
      addRow(dpReg(cAl, armPkg::functAdd, 0, 0, 12, 1, armPkg::shiftRor, 1), 32'h80000002, 0,
             0, 0, 52);
      // Z and C set, then conditional increments of r4
      addRow(dpReg(cAl, armPkg::functSub, 1, 1, 10, 0, armPkg::shiftLsl, 1), 0, 0, 0, 0, 56);
      addRow(dpImm(cEq, armPkg::functAdd, 0, 4, 4, 8'd1), 9, 0, 0, 0, 60);
      addRow(dpImm(cNe, armPkg::functAdd, 0, 4, 4, 8'd1), 10, 0, 0, 0, 64);
      addRow(dpImm(cCs, armPkg::functAdd, 0, 4, 4, 8'd1), 10, 0, 0, 0, 68);
      addRow(dpImm(cCc, armPkg::functAdd, 0, 4, 4, 8'd1), 11, 0, 0, 0, 72);
      addRow(dpImm(cHi, armPkg::functAdd, 0, 4, 4, 8'd1), 11, 0, 0, 0, 76);
      // ORRS clears Z but keeps C
      addRow(dpReg(cAl, armPkg::functOrr, 1, 1, 10, 0, armPkg::shiftLsl, 1), 5, 0, 0, 0, 80);
      addRow(dpImm(cHi, armPkg::functAdd, 0, 4, 4, 8'd1), 11, 0, 0, 0, 84);
      // 3 - 5 gives N, clears C
      addRow(dpReg(cAl, armPkg::functSub, 1, 2, 10, 0, armPkg::shiftLsl, 1), 32'hFFFFFFFE, 0,
             0, 0, 88);
      addRow(dpImm(cMi, armPkg::functAdd, 0, 4, 4, 8'd1), 12, 0, 0, 0, 92);
      addRow(dpImm(cCc, armPkg::functAdd, 0, 4, 4, 8'd1), 13, 0, 0, 0, 96);
      addRow(dpImm(cLt, armPkg::functAdd, 0, 4, 4, 8'd1), 14, 0, 0, 0, 100);
      addRow(dpImm(cGe, armPkg::functAdd, 0, 4, 4, 8'd1), 15, 0, 0, 0, 104);
      addRow(dpImm(cLe, armPkg::functAdd, 0, 4, 4, 8'd1), 15, 0, 0, 0, 108);
      addRow(dpImm(cGt, armPkg::functAdd, 0, 4, 4, 8'd1), 16, 0, 0, 0, 112);
      addRow(dpReg(cAl, armPkg::functSub, 1, 1, 10, 0, armPkg::shiftLsl, 2), 2, 0, 0, 0, 116);
      addRow(dpImm(cGt, armPkg::functAdd, 0, 4, 4, 8'd1), 16, 0, 0, 0, 120);
      // Skipped store, then store and loads
      addRow(memOp(cEq, 0, 0, 4, 12'h40), 32'h40, 1, 16, 0, 124);
      addRow(memOp(cAl, 0, 0, 7, 12'h40), 32'h40, 1, 32'h3D, 1, 128);
      addRow(memOp(cAl, 1, 0, 13, 12'h40), 32'h40, 0, 0, 0, 132);
      addRow(memOp(cAl, 1, 0, 12, 12'h44), 32'h44, 0, 0, 0, 136);
      addRow(dpReg(cAl, armPkg::functAdd, 0, 13, 11, 0, armPkg::shiftLsl, 12),
             32'h3D + memFill(17), 1, memFill(17), 0, 140);
      // Branches and link
      addRow(branchOp(cAl, 0, 24'd2), 156, 0, 0, 0, 156);
      addRow(branchOp(cAl, 1, 24'd1), 168, 0, 0, 0, 168);
      addRow(dpImm(cAl, armPkg::functAdd, 0, 14, 10, 8'd0), 160, 0, 0, 0, 172);
      addRow(branchOp(cAl, 0, 24'hFFFFFD), 168, 0, 0, 0, 168);
      addRow(dpImm(cAl, armPkg::functAdd, 0, 15, 10, 8'd0), 176, 0, 0, 0, 172);
      // Accumulate once under stalls, never condition
      addRow(dpImm(cAl, armPkg::functAdd, 0, 4, 4, 8'd1), 17, 0, 0, 0, 176);
      addRow(dpImm(cAl, armPkg::functAdd, 0, 4, 10, 8'd0), 17, 0, 0, 0, 180);
      addRow(dpImm(cNv, armPkg::functAdd, 0, 4, 4, 8'd1), 18, 0, 0, 0, 184);
      addRow(dpImm(cAl, armPkg::functAdd, 0, 4, 10, 8'd0), 17, 0, 0, 0, 188);
   endtask

   // Galois LFSR, one step per bit
   function automatic logic [31:0] lfsrStep(input logic [31:0] state);
      logic [31:0] next;
      next = state >> 1;
      if (state[0])
      begin
         next = next ^ 32'hA3000000;
      end
      return next;
   endfunction

   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         $display(">>> FAIL");
         $fatal(1);
      end
   endtask

   // One row, repeated through stalls until it commits
   task automatic applyRow(input stimRow r);
      logic committed;
      logic stall;
      logic [31:0] pcBefore;
      committed = 1'b0;
      while (!committed)
      begin
         @(negedge clk);
         Instr = r.instr;
         stall = lfsrState[0];
         lfsrState = lfsrStep(lfsrState);
         PCReady = ~stall;
         pcBefore = PC;
         #2;
         checkValue("ALUResult", ALUResult, r.alu);
         if (r.chkWd)
         begin
            checkValue("WriteData", WriteData, r.wd);
         end
         checkValue("MemWrite", {31'b0, MemWrite}, {31'b0, r.memW & ~stall});
         checkValue("MemStrobe", {31'b0, MemStrobe}, {31'b0, r.instr[27:26] == 2'b01});
         @(posedge clk);
         #1;
         if (stall)
         begin
            checkValue("PC", PC, pcBefore);
         end
         else
         begin
            checkValue("PC", PC, r.pc);
            committed = 1'b1;
         end
      end
   endtask

   initial
   begin
      lfsrState = 32'h86d19af6;
      tableReady = 1'b0;
      Instr = '0;
      PCReady = 1'b0;
      reset = 1'b0;
      buildTable();
      tableReady = 1'b1;
      #1;
      reset = 1'b1;
      repeat (8) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      checkValue("PC", PC, 32'd0);
      foreach (rows[i])
      begin
         applyRow(rows[i]);
      end
      $display(">>> PASS");
      $finish;
   end

   // Watchdog sized from the table length
   initial
   begin
      longint limitNs;
      wait (tableReady);
      limitNs = (longint'(rows.size()) * 40 + 8) * clkPeriod + 10;
      #(limitNs * 1ns);
      $display("Watchdog expired before all rows committed");
      $display(">>> FAIL");
      $fatal(1);
   end

endmodule

/* files.f */
src/armPkg.sv
src/alu.sv
src/operandUnit.sv
src/regFile.sv
src/pcUnit.sv
src/condUnit.sv
src/instrDecoder.sv
src/armCore.sv
bench/armCore_properties.sv
bench/armCoreTb.sv

/* Makefile */
# Verilator build and run for the ARM core testbench

VERILATOR ?= verilator
TOP ?= armCoreTb
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing
LINTFLAGS ?= --lint-only --timing

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '>>> FAIL' $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@grep -qF '>>> PASS' $(LOG) || (echo "Simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
